/* logic/fxdiv_pkg.sv */
package fxdiv_pkg;

    // Controller states
    typedef enum logic [2:0] {
        IDLE,
        LOAD,   // Operands captured, core cleared
        CALC,   // One quotient bit per cycle
        ROUND,
        SIGN
    } fxdiv_state_t;

    // One-cycle commands from the controller to the datapath
    typedef struct packed {
        logic load;     // Capture operand magnitudes and sign
        logic init;     // Clear the core
        logic step;     // One shift-subtract iteration
        logic round;    // Register the rounded magnitude
        logic commit;   // Write the signed result
    } fxdiv_cmd_t;

    // Findings of the operand stage
    typedef struct packed {
        logic zero_div; // Divisor is zero
        logic extreme;  // An operand is the most negative value
        logic neg;      // Quotient is negative
    } fxdiv_prep_flags_t;

    // Result flags, held until the next accepted start
    typedef struct packed {
        logic valid;
        logic dbz;
        logic ovf;
    } fxdiv_status_t;

endpackage

/* logic/fxdiv_operand_prep.sv */
module fxdiv_operand_prep #(
    parameter int WIDTH = 18
) (
    input  logic                         clk,
    input  logic                         rstn,
    input  fxdiv_pkg::fxdiv_cmd_t        cmd,
    input  logic signed [WIDTH-1:0]      a,
    input  logic signed [WIDTH-1:0]      b,
    output logic [WIDTH-2:0]             mag_a,
    output logic [WIDTH-2:0]             mag_b,
    output fxdiv_pkg::fxdiv_prep_flags_t prep_flags
);

    localparam logic [WIDTH-1:0] MOST_NEG = {1'b1, {(WIDTH-1){1'b0}}};

    logic [WIDTH-1:0] abs_a;
    logic [WIDTH-1:0] abs_b;
    logic             neg_q;

    always_comb begin
        abs_a = a[WIDTH-1] ? -a : a;
        abs_b = b[WIDTH-1] ? -b : b;
    end

    // Checked live, the controller looks at these in IDLE
    always_comb begin
        prep_flags.zero_div = (b == '0);
        prep_flags.extreme  = ($unsigned(a) == MOST_NEG) || ($unsigned(b) == MOST_NEG);
        prep_flags.neg      = neg_q;
    end

    // Top bit of abs is zero for every operand that reaches the core
    always_ff @(posedge clk) begin
        if (cmd.load) begin
            mag_a <= abs_a[WIDTH-2:0];
            mag_b <= abs_b[WIDTH-2:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            neg_q <= 1'b0;
        end else if (cmd.load) begin
            neg_q <= a[WIDTH-1] ^ b[WIDTH-1];  // Signs differ
        end
    end

endmodule

/* logic/fxdiv_restoring_core.sv */
module fxdiv_restoring_core #(
    parameter int WIDTH    = 18,
    parameter int FRACBITS = 12
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  fxdiv_pkg::fxdiv_cmd_t cmd,
    input  logic [WIDTH-2:0]      mag_a,
    input  logic [WIDTH-2:0]      mag_b,
    output logic [WIDTH-2:0]      quo_mag,
    output logic                  guard,
    output logic                  sticky,
    output logic                  int_ovf
);

    // Quotient bits: WIDTH-1 integer+fraction field, FRACBITS above it, one guard
    localparam int ITER = WIDTH - 1 + FRACBITS + 1;
    localparam int HW   = $clog2(FRACBITS + 2);

    logic [WIDTH-1:0] rem;      // Partial remainder
    logic [ITER-1:0]  dvd;      // Dividend bits out the top, quotient bits in the bottom
    logic [HW-1:0]    hi_left;  // Steps left whose quotient bit lies above quo_mag
    logic [WIDTH-1:0] trial;
    logic [WIDTH-1:0] rem_next;
    logic             fits;

    // One restoring iteration
    always_comb begin
        trial    = {rem[WIDTH-2:0], dvd[ITER-1]};
        fits     = (trial >= {1'b0, mag_b});
        rem_next = fits ? trial - {1'b0, mag_b} : trial;
    end

    always_ff @(posedge clk) begin
        if (cmd.init) begin
            rem <= '0;
            dvd <= {mag_a, {(FRACBITS + 1){1'b0}}};  // |a| scaled by 2^(FRACBITS+1)
        end else if (cmd.step) begin
            rem <= rem_next;
            dvd <= {dvd[ITER-2:0], fits};
        end
    end

    // Early overflow watch over the first FRACBITS quotient bits
    always_ff @(posedge clk) begin
        if (!rstn) begin
            hi_left <= '0;
            int_ovf <= 1'b0;
        end else if (cmd.init) begin
            hi_left <= HW'(FRACBITS);
            int_ovf <= 1'b0;
        end else if (cmd.step && hi_left != '0) begin
            hi_left <= hi_left - 1'b1;
            if (fits) begin
                int_ovf <= 1'b1;  // Set bit beyond the top of quo_mag
            end
        end
    end

    // Valid once the last step is done
    always_comb begin
        quo_mag = dvd[WIDTH-1:1];
        guard   = dvd[0];
        sticky  = (rem != '0);
    end

endmodule

/* logic/fxdiv_round_sign.sv */
module fxdiv_round_sign #(
    parameter int WIDTH = 18
) (
    input  logic                         clk,
    input  logic                         rstn,
    input  fxdiv_pkg::fxdiv_cmd_t        cmd,
    input  logic [WIDTH-2:0]             quo_mag,
    input  logic                         guard,
    input  logic                         sticky,
    input  fxdiv_pkg::fxdiv_prep_flags_t prep_flags,
    output logic                         round_ovf,
    output logic signed [WIDTH-1:0]      val
);

    localparam int MW = WIDTH - 1;  // Magnitude width

    logic          inc;
    logic [MW:0]   sum;     // Carry in the top bit
    logic [MW-1:0] rnd_mag;
    logic [WIDTH-1:0] mag_ext;

    // Half to even: up when guard and (odd or anything below guard)
    always_comb begin
        inc = guard & (quo_mag[0] | sticky);
        sum = {1'b0, quo_mag} + {{MW{1'b0}}, inc};
        mag_ext = {1'b0, rnd_mag};
    end

    always_ff @(posedge clk) begin
        if (cmd.round) begin
            rnd_mag <= sum[MW-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            round_ovf <= 1'b0;
            val       <= '0;
        end else begin
            if (cmd.round) begin
                round_ovf <= sum[MW];  // Rounded past the largest magnitude
            end
            if (cmd.commit) begin
                if (rnd_mag == '0) begin
                    val <= '0;  // No negative zero
                end else if (prep_flags.neg) begin
                    val <= -mag_ext;
                end else begin
                    val <= mag_ext;
                end
            end
        end
    end

endmodule

/* logic/fxdiv_control.sv */
module fxdiv_control #(
    parameter int WIDTH    = 18,
    parameter int FRACBITS = 12
) (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         start,
    input  fxdiv_pkg::fxdiv_prep_flags_t prep_flags,
    input  logic                         int_ovf,
    input  logic                         round_ovf,
    output fxdiv_pkg::fxdiv_cmd_t        cmd,
    output logic                         busy,
    output logic                         done,
    output fxdiv_pkg::fxdiv_status_t     status
);

    localparam int ITER   = WIDTH - 1 + FRACBITS + 1;
    localparam int ITER_W = $clog2(ITER + 1);

    fxdiv_pkg::fxdiv_state_t state;
    logic [ITER_W-1:0]       iter;
    logic                    pend_dbz;  // Special case decided in IDLE
    logic                    pend_ovf;

    // Commands are decoded from the state, load is taken on the start edge itself
    always_comb begin
        cmd.load   = (state == fxdiv_pkg::IDLE) && start;
        cmd.init   = (state == fxdiv_pkg::LOAD) && !(pend_dbz || pend_ovf);
        cmd.step   = (state == fxdiv_pkg::CALC) && !int_ovf;
        cmd.round  = (state == fxdiv_pkg::ROUND);
        cmd.commit = (state == fxdiv_pkg::SIGN) && !round_ovf;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= fxdiv_pkg::IDLE;
            iter     <= '0;
            pend_dbz <= 1'b0;
            pend_ovf <= 1'b0;
            busy     <= 1'b0;
            done     <= 1'b0;
            status   <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                fxdiv_pkg::IDLE: begin
                    if (start) begin
                        busy     <= 1'b1;
                        status   <= '0;  // Flags of the last result dropped
                        pend_dbz <= prep_flags.zero_div;
                        pend_ovf <= !prep_flags.zero_div && prep_flags.extreme;
                        state    <= fxdiv_pkg::LOAD;
                    end
                end
                fxdiv_pkg::LOAD: begin
                    if (pend_dbz || pend_ovf) begin
                        busy       <= 1'b0;
                        done       <= 1'b1;
                        status.dbz <= pend_dbz;
                        status.ovf <= pend_ovf;
                        state      <= fxdiv_pkg::IDLE;
                    end else begin
                        iter  <= '0;
                        state <= fxdiv_pkg::CALC;
                    end
                end
                fxdiv_pkg::CALC: begin
                    if (int_ovf) begin
                        // Quotient already too large, stop here
                        busy       <= 1'b0;
                        done       <= 1'b1;
                        status.ovf <= 1'b1;
                        state      <= fxdiv_pkg::IDLE;
                    end else begin
                        iter <= iter + 1'b1;
                        if (iter == ITER_W'(ITER - 1)) begin
                            state <= fxdiv_pkg::ROUND;
                        end
                    end
                end
                fxdiv_pkg::ROUND: begin
                    state <= fxdiv_pkg::SIGN;
                end
                fxdiv_pkg::SIGN: begin
                    busy <= 1'b0;
                    done <= 1'b1;
                    if (round_ovf) begin
                        status.ovf <= 1'b1;  // val left as it was
                    end else begin
                        status.valid <= 1'b1;
                    end
                    state <= fxdiv_pkg::IDLE;
                end
                default: begin
                    state <= fxdiv_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

/* logic/fxdiv_top.sv */
module fxdiv_top #(
    parameter int WIDTH    = 18,
    parameter int FRACBITS = 12
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    start,
    input  logic signed [WIDTH-1:0] a,  // Dividend
    input  logic signed [WIDTH-1:0] b,  // Divisor
    output logic                    busy,
    output logic                    done,
    output logic                    valid,
    output logic                    dbz,
    output logic                    ovf,
    output logic signed [WIDTH-1:0] val
);

    fxdiv_pkg::fxdiv_cmd_t        cmd;
    fxdiv_pkg::fxdiv_prep_flags_t prep_flags;
    fxdiv_pkg::fxdiv_status_t     status;
    logic [WIDTH-2:0]             mag_a;
    logic [WIDTH-2:0]             mag_b;
    logic [WIDTH-2:0]             quo_mag;
    logic                         guard;
    logic                         sticky;
    logic                         int_ovf;
    logic                         round_ovf;

    fxdiv_control #(
        .WIDTH    (WIDTH),
        .FRACBITS (FRACBITS)
    ) u_control (
        .clk        (clk),
        .rstn       (rstn),
        .start      (start),
        .prep_flags (prep_flags),
        .int_ovf    (int_ovf),
        .round_ovf  (round_ovf),
        .cmd        (cmd),
        .busy       (busy),
        .done       (done),
        .status     (status)
    );

    fxdiv_operand_prep #(
        .WIDTH (WIDTH)
    ) u_operand_prep (
        .clk        (clk),
        .rstn       (rstn),
        .cmd        (cmd),
        .a          (a),
        .b          (b),
        .mag_a      (mag_a),
        .mag_b      (mag_b),
        .prep_flags (prep_flags)
    );

    fxdiv_restoring_core #(
        .WIDTH    (WIDTH),
        .FRACBITS (FRACBITS)
    ) u_core (
        .clk     (clk),
        .rstn    (rstn),
        .cmd     (cmd),
        .mag_a   (mag_a),
        .mag_b   (mag_b),
        .quo_mag (quo_mag),
        .guard   (guard),
        .sticky  (sticky),
        .int_ovf (int_ovf)
    );

    fxdiv_round_sign #(
        .WIDTH (WIDTH)
    ) u_round_sign (
        .clk        (clk),
        .rstn       (rstn),
        .cmd        (cmd),
        .quo_mag    (quo_mag),
        .guard      (guard),
        .sticky     (sticky),
        .prep_flags (prep_flags),
        .round_ovf  (round_ovf),
        .val        (val)
    );

    // Status flags out as separate ports
    assign valid = status.valid;
    assign dbz   = status.dbz;
    assign ovf   = status.ovf;

endmodule

/* test/fxdiv_properties.sv */
module fxdiv_properties (
    input logic                     clk,
    input logic                     rstn,
    input fxdiv_pkg::fxdiv_state_t  state,
    input logic                     busy,
    input logic                     done,
    input fxdiv_pkg::fxdiv_status_t status
);

    timeunit 1ns;
    timeprecision 1ps;

    // Single-cycle done pulse
    done_one_cycle: assert property (@(posedge clk) disable iff (!rstn) done |=> !done)
        else $error("done held high for more than one cycle");

    // busy drops exactly with done
    busy_fall_at_done: assert property (@(posedge clk) disable iff (!rstn) $fell(busy) |-> done)
        else $error("busy fell without a done pulse");

    done_ends_busy: assert property (@(posedge clk) disable iff (!rstn) done |-> $fell(busy))
        else $error("done pulsed while busy did not fall");

    dbz_ovf_exclusive: assert property (@(posedge clk) disable iff (!rstn)
        !(status.dbz && status.ovf))
        else $error("dbz and ovf both set");

    valid_alone: assert property (@(posedge clk) disable iff (!rstn)
        status.valid |-> !status.dbz && !status.ovf)
        else $error("valid set together with an error flag");

    busy_tracks_state: assert property (@(posedge clk) disable iff (!rstn)
        busy == (state != fxdiv_pkg::IDLE))
        else $error("busy does not match the controller state");

endmodule

/* test/fxdiv_tb.sv */
module fxdiv_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WIDTH       = 18;
    localparam int FRACBITS    = 12;
    localparam int ITER        = WIDTH - 1 + FRACBITS + 1;
    localparam int NUM_CASES   = 19;
    localparam int NUM_RAND    = 20;
    localparam int CYCLE_LIMIT = (NUM_CASES + NUM_RAND) * 40 + 100;
    localparam logic [WIDTH-1:0] MOST_NEG = {1'b1, {(WIDTH-1){1'b0}}};
    localparam longint MAX_MAG = (longint'(1) << (WIDTH - 1)) - 1;

    logic                    clk;
    logic                    rstn;
    logic                    start;
    logic signed [WIDTH-1:0] a;
    logic signed [WIDTH-1:0] b;
    logic                    busy;
    logic                    done;
    logic                    valid;
    logic                    dbz;
    logic                    ovf;
    logic signed [WIDTH-1:0] val;

    logic [WIDTH-1:0] case_mem [0:NUM_CASES*6-1];  // Six words per case line
    int               errors;
    int               cycle_count;
    integer           seed;

    fxdiv_top dut (
        .clk   (clk),
        .rstn  (rstn),
        .start (start),
        .a     (a),
        .b     (b),
        .busy  (busy),
        .done  (done),
        .valid (valid),
        .dbz   (dbz),
        .ovf   (ovf),
        .val   (val)
    );

    bind fxdiv_control fxdiv_properties u_properties (
        .clk    (clk),
        .rstn   (rstn),
        .state  (state),
        .busy   (busy),
        .done   (done),
        .status (status)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Run limit
    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        errors++;
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Errors: %0d", errors);
        $display("Testbench failed");
        $finish;
    end

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("FAILED %s: expected %h, got %h at %0t", name, expected, actual, $time);
        end
    endtask

    function automatic longint magnitude(input logic [WIDTH-1:0] x);
        if (x[WIDTH-1]) begin
            return (longint'(1) << WIDTH) - longint'(x);
        end
        return longint'(x);
    endfunction

    // floor(|x| * 2^FRACBITS / |y|)
    function automatic longint raw_quotient(input logic [WIDTH-1:0] x,
                                            input logic [WIDTH-1:0] y);
        return (magnitude(x) << FRACBITS) / magnitude(y);
    endfunction

    // Cycles from the start edge to done
    function automatic int expected_latency(input logic [WIDTH-1:0] x,
                                            input logic [WIDTH-1:0] y);
        longint q;
        int     k;
        if (y == '0 || x == MOST_NEG || y == MOST_NEG) begin
            return 1;
        end
        if (raw_quotient(x, y) <= MAX_MAG) begin
            return ITER + 3;
        end
        // Abort comes right after the step that yields the first set quotient bit
        q = (magnitude(x) << (FRACBITS + 1)) / magnitude(y);
        k = 0;
        while (!q[ITER-1-k]) begin
            k++;
        end
        return k + 3;
    endfunction

    task automatic run_division(input logic [WIDTH-1:0] a_in, input logic [WIDTH-1:0] b_in,
                                output int latency);
        latency = 0;
        @(negedge clk);
        a     = a_in;
        b     = b_in;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        compare_value("busy", 1, busy);
        compare_value("valid", 0, valid);  // Old flags dropped at start
        compare_value("dbz", 0, dbz);
        compare_value("ovf", 0, ovf);
        while (!done && latency < ITER + 8) begin
            @(negedge clk);
            latency++;
            if (latency == 4 && busy && !done) begin
                start = 1'b1;  // Must be ignored while busy
                a     = ~a_in;
                b     = '0;
            end else if (latency == 5) begin
                start = 1'b0;
                a     = a_in;
                b     = b_in;
            end
        end
        if (!done) begin
            errors++;
            $display("No done pulse within %0d cycles for a=%h b=%h", latency, a_in, b_in);
        end
    endtask

    task automatic check_result(input logic [WIDTH-1:0] exp_val, input logic exp_valid,
                                input logic exp_dbz, input logic exp_ovf);
        compare_value("val", exp_val, $unsigned(val));
        compare_value("valid", exp_valid, valid);
        compare_value("dbz", exp_dbz, dbz);
        compare_value("ovf", exp_ovf, ovf);
        compare_value("busy", 0, busy);
    endtask

    task automatic outputs_cleared();
        compare_value("busy", 0, busy);
        compare_value("done", 0, done);
        compare_value("valid", 0, valid);
        compare_value("dbz", 0, dbz);
        compare_value("ovf", 0, ovf);
        compare_value("val", 0, $unsigned(val));
    endtask

    initial begin
        int               latency;
        logic [WIDTH-1:0] ra;
        logic [WIDTH-1:0] rb;
        logic             exp_dbz;
        logic             exp_ovf;

        errors = 0;
        seed   = 1335;
        rstn   = 1'b0;
        start  = 1'b0;
        a      = '0;
        b      = '0;
        $readmemh("test/fxdiv_cases.txt", case_mem);

        repeat (8) @(negedge clk);
        outputs_cleared();
        rstn = 1'b1;

        for (int i = 0; i < NUM_CASES; i++) begin
            if (case_mem[6*i+3] + case_mem[6*i+4] + case_mem[6*i+5] != 1) begin
                errors++;
                $display("Case %0d of the case file does not set exactly one flag", i);
            end
            run_division(case_mem[6*i], case_mem[6*i+1], latency);
            compare_value("latency", expected_latency(case_mem[6*i], case_mem[6*i+1]),
                          latency);
            check_result(case_mem[6*i+2], case_mem[6*i+3][0], case_mem[6*i+4][0],
                         case_mem[6*i+5][0]);
            // Result holds with no new start
            repeat (2) @(negedge clk);
            compare_value("done", 0, done);
            check_result(case_mem[6*i+2], case_mem[6*i+3][0], case_mem[6*i+4][0],
                         case_mem[6*i+5][0]);
        end

        // Reset in the middle of a division
        @(negedge clk);
        a     = 18'h03000;
        b     = 18'h02000;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        repeat (10) @(negedge clk);
        rstn = 1'b0;
        @(negedge clk);
        outputs_cleared();
        repeat (2) @(negedge clk);
        rstn = 1'b1;

        for (int i = 0; i < NUM_RAND; i++) begin
            ra = WIDTH'($random(seed));
            rb = WIDTH'($random(seed));
            if (i % 2 == 1) begin
                rb = {{(WIDTH-8){rb[7]}}, rb[7:0]};  // Small divisor for large quotients
            end
            if (i == 6) begin
                rb = '0;
            end else if (i == 13) begin
                ra = MOST_NEG;
            end
            exp_dbz = (rb == '0);
            exp_ovf = !exp_dbz && (ra == MOST_NEG || rb == MOST_NEG);
            run_division(ra, rb, latency);
            compare_value("latency", expected_latency(ra, rb), latency);
            compare_value("dbz", exp_dbz, dbz);
            if (exp_dbz || exp_ovf) begin
                compare_value("ovf", exp_ovf, ovf);
                compare_value("valid", 0, valid);
            end else begin
                compare_value("valid ^ ovf", 1, valid ^ ovf);
            end
        end

        $display("Cases: %0d from file, %0d random, errors: %0d", NUM_CASES, NUM_RAND, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* test/fxdiv_cases.txt */
// a b val valid dbz ovf, hex, operands and val are 18-bit Q5.12
// On dbz and ovf rows val is the previous row's result, which the DUT keeps
01000 01000 01000 1 0 0
03000 02000 01800 1 0 0
3D000 02000 3E800 1 0 0
03000 3E000 3E800 1 0 0
3D000 3E000 01800 1 0 0
01000 03000 00555 1 0 0
3F000 03000 3FAAB 1 0 0
02000 3D000 3F555 1 0 0
00005 02000 00002 1 0 0
3FFF9 02000 3FFFC 1 0 0
1FFFF 01000 1FFFF 1 0 0
01000 00000 1FFFF 0 1 0
20000 01000 1FFFF 0 0 1
01000 20000 1FFFF 0 0 1
20000 00000 1FFFF 0 1 0
10000 00001 1FFFF 0 0 1
1FFFF 00FFF 1FFFF 0 0 1
3FFFF 03000 00000 1 0 0
3F000 3D000 00555 1 0 0

/* filelist.f */
logic/fxdiv_pkg.sv
logic/fxdiv_operand_prep.sv
logic/fxdiv_restoring_core.sv
logic/fxdiv_round_sign.sv
logic/fxdiv_control.sv
logic/fxdiv_top.sv
test/fxdiv_properties.sv
test/fxdiv_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal --timescale 1ns/1ps
TOP       = fxdiv_tb
FILELIST  = filelist.f
LOG       = sim.log
PASS_MSG  = Testbench passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
